/* hw/cpu_pkg.sv */
package cpu_pkg;

	// Datapath and storage sizes
	localparam int word_w     = 16;
	localparam int reg_addr_w = 4;
	localparam int imem_depth = 256;
	localparam int dmem_depth = 256;

	// --------------------
	// ISA encodings
	// --------------------

	// Opcode lives in bits 15:12 of every instruction
	typedef enum logic [3:0] {
		ADD = 4'd0,
		SUB = 4'd1,
		XOR = 4'd2,
		AND = 4'd3,
		SLL = 4'd4,
		SRA = 4'd5,
		ROR = 4'd6,
		LW  = 4'd8,
		SW  = 4'd9,
		LHB = 4'd10,
		LLB = 4'd11,
		B   = 4'd12,
		BR  = 4'd13,
		PCS = 4'd14,
		HLT = 4'd15
	} opcode_e;

	// Branch condition in bits 11:9
	typedef enum logic [2:0] {
		NE     = 3'd0,
		EQ     = 3'd1,
		GT     = 3'd2,
		LT     = 3'd3,
		GE     = 3'd4,
		LE     = 3'd5,
		OV     = 3'd6,
		ALWAYS = 3'd7
	} cond_e;

	// Register form, also memory ops with imm4 in the rt slot
	typedef struct packed {
		opcode_e               opcode;
		logic [reg_addr_w-1:0] rd;
		logic [reg_addr_w-1:0] rs;
		logic [reg_addr_w-1:0] rt;
	} r_form_t;

	// Byte immediate form
	typedef struct packed {
		opcode_e               opcode;
		logic [reg_addr_w-1:0] rd;
		logic [7:0]            imm8;
	} i_form_t;

	// Branch form
	typedef struct packed {
		opcode_e    opcode;
		cond_e      cond;
		logic [8:0] imm9;
	} b_form_t;

	// One instruction word, three views
	typedef union packed {
		r_form_t r;
		i_form_t i;
		b_form_t b;
	} instr_u;

	typedef struct packed {
		logic z;
		logic v;
		logic n;
	} flags_t;

	// Operand source for the execute muxes
	typedef enum logic [1:0] {
		REG,
		MEM,
		WB
	} fwd_sel_e;

endpackage

/* hw/cpu_bus.sv */
// Decode to execute, sampled by the ID/EX register
interface dx_bus;
	import cpu_pkg::*;

	logic [word_w-1:0]     pc_plus2;
	instr_u                instr;
	logic [word_w-1:0]     rs_data;
	logic [word_w-1:0]     rt_data;
	// Indices actually read, for forwarding
	logic [reg_addr_w-1:0] rs_idx;
	logic [reg_addr_w-1:0] rt_idx;
	logic                  valid;

	modport source (output pc_plus2, instr, rs_data, rt_data, rs_idx, rt_idx, valid);
	modport sink (input pc_plus2, instr, rs_data, rt_data, rs_idx, rt_idx, valid);
endinterface

// Execute to memory/write-back, sampled by the EX/MEM register
interface xr_bus;
	import cpu_pkg::*;

	logic [word_w-1:0]     wb_data;
	logic [reg_addr_w-1:0] dst;
	logic                  reg_write;
	logic                  mem_read;
	logic                  mem_write;
	logic [word_w-1:0]     mem_addr;
	logic [word_w-1:0]     store_data;
	logic                  halt;
	logic                  valid;

	modport source (output wb_data, dst, reg_write, mem_read, mem_write, mem_addr,
		store_data, halt, valid);
	modport sink (input wb_data, dst, reg_write, mem_read, mem_write, mem_addr,
		store_data, halt, valid);
endinterface

/* hw/fetch_unit.sv */
module fetch_unit (
	input  logic                       clk,
	input  logic                       rst_n,
	input  logic                       stall,
	input  logic                       halted,
	input  logic                       branch_taken,
	input  logic [cpu_pkg::word_w-1:0] branch_target,
	output logic [cpu_pkg::word_w-1:0] pc,
	output logic [cpu_pkg::word_w-1:0] pc_plus2,
	output logic [cpu_pkg::word_w-1:0] instr,
	output logic                       valid
);
	import cpu_pkg::*;

	// Word-addressed program store
	logic [word_w-1:0] imem [imem_depth];

	// --------------------
	// Program load
	// --------------------

	// Unused words read as HLT so running off the end stops cleanly
	initial begin
		for (int i = 0; i < imem_depth; i++) begin
			imem[i] = {HLT, 12'h000};
		end
		$readmemh("prog.hex", imem);
	end

	// --------------------
	// PC register
	// --------------------

	assign pc_plus2 = pc + word_w'(2);

	// Hold on load-use stall or after halt, else redirect or step
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pc <= '0;
		end else if (!halted && !stall) begin
			pc <= branch_taken ? branch_target : pc_plus2;
		end
	end

	// Byte address to word index
	assign instr = imem[pc[$clog2(imem_depth):1]];

	// Nothing new enters decode once halted
	assign valid = !halted;

	// BR target comes from a register in execute
	a_pc_even: assert property (@(posedge clk) disable iff (!rst_n) !pc[0]);

endmodule

/* hw/decode_stage.sv */
module decode_stage (
	input  logic                           clk,
	input  logic                           rst_n,
	input  logic [cpu_pkg::word_w-1:0]     pc_plus2,
	input  logic [cpu_pkg::word_w-1:0]     instr,
	input  logic                           valid,
	input  logic                           branch_taken,
	input  logic                           wb_en,
	input  logic [cpu_pkg::reg_addr_w-1:0] wb_reg,
	input  logic [cpu_pkg::word_w-1:0]     wb_data,
	input  logic                           ex_mem_read,
	input  logic [cpu_pkg::reg_addr_w-1:0] ex_dst,
	output logic                           stall,
	dx_bus.source                          dx
);
	import cpu_pkg::*;

	// IF/ID register
	logic              id_valid;
	logic [word_w-1:0] id_pc_plus2;
	instr_u            id_instr;

	// Decoded fields and controls
	opcode_e               op;
	logic                  rd_first;
	logic [reg_addr_w-1:0] src1;
	logic [reg_addr_w-1:0] src2;
	logic                  use1;
	logic                  use2;

	// Sixteen general registers, r0 included
	logic [word_w-1:0] regs [1 << reg_addr_w];

	// --------------------
	// IF/ID register
	// --------------------

	// Taken branch kills the slot, stall freezes it
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			id_valid <= 1'b0;
		end else if (branch_taken) begin
			id_valid <= 1'b0;
		end else if (!stall) begin
			id_valid <= valid;
		end
	end

	always_ff @(posedge clk) begin
		if (!stall) begin
			id_pc_plus2 <= pc_plus2;
			id_instr    <= instr;
		end
	end

	// --------------------
	// Field decode
	// --------------------

	assign op = id_instr.r.opcode;

	// Store data and byte merges take rd as first operand
	assign rd_first = op inside {SW, LHB, LLB};
	assign src1     = rd_first ? id_instr.r.rd : id_instr.r.rs;
	// SW base address rides on the second port
	assign src2     = (op == SW) ? id_instr.r.rs : id_instr.r.rt;

	// Which read ports carry a real operand
	assign use1 = op inside {ADD, SUB, XOR, AND, SLL, SRA, ROR, LW, SW, LHB, LLB, BR};
	assign use2 = op inside {ADD, SUB, XOR, AND, SW};

	// --------------------
	// Register file
	// --------------------

	always_ff @(posedge clk) begin
		if (wb_en) begin
			regs[wb_reg] <= wb_data;
		end
	end

	// Write in the same cycle shows up on the read
	assign dx.rs_data = (wb_en && wb_reg == src1) ? wb_data : regs[src1];
	assign dx.rt_data = (wb_en && wb_reg == src2) ? wb_data : regs[src2];

	assign dx.pc_plus2 = id_pc_plus2;
	assign dx.instr    = id_instr;
	assign dx.rs_idx   = src1;
	assign dx.rt_idx   = src2;
	assign dx.valid    = id_valid;

	// Load in execute feeding this instruction
	assign stall = id_valid && ex_mem_read &&
		((use1 && src1 == ex_dst) || (use2 && src2 == ex_dst));

	// Execute takes a bubble, so one stall cycle per load
	a_stall_once: assert property (@(posedge clk) disable iff (!rst_n)
		stall |=> !stall);

	a_ctrl_known: assert property (@(posedge clk) disable iff (!rst_n)
		!$isunknown({wb_en, stall}));

endmodule

/* hw/execute_stage.sv */
module execute_stage (
	input  logic                           clk,
	input  logic                           rst_n,
	input  logic                           stall,
	dx_bus.sink                            dx,
	input  logic                           mem_fwd_en,
	input  logic [cpu_pkg::reg_addr_w-1:0] mem_fwd_reg,
	input  logic [cpu_pkg::word_w-1:0]     mem_fwd_data,
	input  logic                           wb_en,
	input  logic [cpu_pkg::reg_addr_w-1:0] wb_reg,
	input  logic [cpu_pkg::word_w-1:0]     wb_data,
	output logic                           branch_taken,
	output logic [cpu_pkg::word_w-1:0]     branch_target,
	output logic                           ex_mem_read,
	output logic [cpu_pkg::reg_addr_w-1:0] ex_dst,
	xr_bus.source                          xr
);
	import cpu_pkg::*;

	// ID/EX register
	logic                  ex_valid;
	logic [word_w-1:0]     ex_pc_plus2;
	instr_u                ex_instr;
	logic [word_w-1:0]     ex_rs_data;
	logic [word_w-1:0]     ex_rt_data;
	logic [reg_addr_w-1:0] ex_rs_idx;
	logic [reg_addr_w-1:0] ex_rt_idx;

	opcode_e             op;
	logic                is_alu;
	logic                is_branch;
	fwd_sel_e            fwd_a;
	fwd_sel_e            fwd_b;
	logic [word_w-1:0]   op_a;
	logic [word_w-1:0]   op_b;
	logic [2*word_w-1:0] ror_pair;
	logic [word_w-1:0]   alu_out;
	logic                ovf;
	logic [word_w-1:0]   result;
	flags_t              flags;
	logic                cond_true;
	logic [word_w-1:0]   br_offset;
	logic [word_w-1:0]   mem_base;
	logic [word_w-1:0]   mem_offset;

	// Newest producer wins, mem stage ahead of write-back
	function automatic fwd_sel_e pick_src(input logic [reg_addr_w-1:0] idx,
			input logic m_en, input logic [reg_addr_w-1:0] m_reg,
			input logic w_en, input logic [reg_addr_w-1:0] w_reg);
		if (m_en && m_reg == idx)
			return MEM;
		if (w_en && w_reg == idx)
			return WB;
		return REG;
	endfunction

	function automatic logic [word_w-1:0] fwd_value(input fwd_sel_e sel,
			input logic [word_w-1:0] reg_val, input logic [word_w-1:0] mem_val,
			input logic [word_w-1:0] wb_val);
		case (sel)
			MEM:     return mem_val;
			WB:      return wb_val;
			default: return reg_val;
		endcase
	endfunction

	// --------------------
	// ID/EX register
	// --------------------

	// Bubble on stall, squash on taken branch
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ex_valid <= 1'b0;
		end else begin
			ex_valid <= dx.valid && !stall && !branch_taken;
		end
	end

	always_ff @(posedge clk) begin
		ex_pc_plus2 <= dx.pc_plus2;
		ex_instr    <= dx.instr;
		ex_rs_data  <= dx.rs_data;
		ex_rt_data  <= dx.rt_data;
		ex_rs_idx   <= dx.rs_idx;
		ex_rt_idx   <= dx.rt_idx;
	end

	assign op        = ex_instr.r.opcode;
	assign is_alu    = !op[3] && op != 4'd7;
	assign is_branch = (op == B) || (op == BR);

	// Operand forwarding
	assign fwd_a = pick_src(ex_rs_idx, mem_fwd_en, mem_fwd_reg, wb_en, wb_reg);
	assign fwd_b = pick_src(ex_rt_idx, mem_fwd_en, mem_fwd_reg, wb_en, wb_reg);
	assign op_a  = fwd_value(fwd_a, ex_rs_data, mem_fwd_data, wb_data);
	assign op_b  = fwd_value(fwd_b, ex_rt_data, mem_fwd_data, wb_data);

	// --------------------
	// ALU and flags
	// --------------------

	// Rotate via doubled word
	assign ror_pair = {op_a, op_a} >> ex_instr.r.rt;

	always_comb begin
		case (op)
			ADD:     alu_out = op_a + op_b;
			SUB:     alu_out = op_a - op_b;
			XOR:     alu_out = op_a ^ op_b;
			AND:     alu_out = op_a & op_b;
			SLL:     alu_out = op_a << ex_instr.r.rt;
			SRA:     alu_out = $signed(op_a) >>> ex_instr.r.rt;
			ROR:     alu_out = ror_pair[word_w-1:0];
			default: alu_out = '0;
		endcase
	end

	// Signed overflow on wrapped add or subtract
	assign ovf = (op == SUB) ?
		(op_a[word_w-1] != op_b[word_w-1]) && (alu_out[word_w-1] != op_a[word_w-1]) :
		(op_a[word_w-1] == op_b[word_w-1]) && (alu_out[word_w-1] != op_a[word_w-1]);

	// Logic ops and shifts only touch z
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			flags <= '0;
		end else if (ex_valid && is_alu) begin
			flags.z <= (alu_out == '0);
			if (op == ADD || op == SUB) begin
				flags.v <= ovf;
				flags.n <= alu_out[word_w-1];
			end
		end
	end

	// Write-back value, loads replace it later
	always_comb begin
		case (op)
			LHB:     result = {ex_instr.i.imm8, op_a[7:0]};
			LLB:     result = {op_a[15:8], ex_instr.i.imm8};
			PCS:     result = ex_pc_plus2;
			default: result = alu_out;
		endcase
	end

	// --------------------
	// Branch resolution
	// --------------------

	always_comb begin
		cond_true = 1'b0;
		case (ex_instr.b.cond)
			NE:     cond_true = !flags.z;
			EQ:     cond_true = flags.z;
			GT:     cond_true = !flags.z && !flags.n;
			LT:     cond_true = flags.n;
			GE:     cond_true = flags.z || !flags.n;
			LE:     cond_true = flags.z || flags.n;
			OV:     cond_true = flags.v;
			ALWAYS: cond_true = 1'b1;
		endcase
	end

	assign br_offset     = {{(word_w-10){ex_instr.b.imm9[8]}}, ex_instr.b.imm9, 1'b0};
	assign branch_taken  = ex_valid && is_branch && cond_true;
	assign branch_target = (op == BR) ? op_a : ex_pc_plus2 + br_offset;

	// Word-aligned base plus imm4 words; SW base is on port b
	assign mem_base   = (op == SW) ? op_b : op_a;
	assign mem_offset = {{(word_w-5){ex_instr.r.rt[3]}}, ex_instr.r.rt, 1'b0};

	assign xr.wb_data    = result;
	assign xr.dst        = ex_instr.r.rd;
	assign xr.reg_write  = is_alu || op inside {LW, LHB, LLB, PCS};
	assign xr.mem_read   = (op == LW);
	assign xr.mem_write  = (op == SW);
	assign xr.mem_addr   = {mem_base[word_w-1:1], 1'b0} + mem_offset;
	assign xr.store_data = op_a;
	assign xr.halt       = (op == HLT);
	assign xr.valid      = ex_valid;

	// For load-use detection in decode
	assign ex_mem_read = ex_valid && (op == LW);
	assign ex_dst      = ex_instr.r.rd;

	// Decode's slot is squashed on the same edge
	a_branch_flush: assert property (@(posedge clk) disable iff (!rst_n)
		branch_taken |=> !dx.valid);

endmodule

/* hw/result_stage.sv */
module result_stage (
	input  logic                           clk,
	input  logic                           rst_n,
	xr_bus.sink                            xr,
	output logic                           mem_fwd_en,
	output logic [cpu_pkg::reg_addr_w-1:0] mem_fwd_reg,
	output logic [cpu_pkg::word_w-1:0]     mem_fwd_data,
	output logic                           wb_en,
	output logic [cpu_pkg::reg_addr_w-1:0] wb_reg,
	output logic [cpu_pkg::word_w-1:0]     wb_data,
	output logic                           halted
);
	import cpu_pkg::*;

	// EX/MEM register
	logic                  xm_valid;
	logic [word_w-1:0]     xm_wb_data;
	logic [reg_addr_w-1:0] xm_dst;
	logic                  xm_reg_write;
	logic                  xm_mem_read;
	logic                  xm_mem_write;
	logic [word_w-1:0]     xm_mem_addr;
	logic [word_w-1:0]     xm_store_data;
	logic                  xm_halt;

	// MEM/WB register
	logic                  mw_valid;
	logic                  mw_reg_write;
	logic [reg_addr_w-1:0] mw_dst;
	logic [word_w-1:0]     mw_data;

	logic [word_w-1:0]                dmem [dmem_depth];
	logic [$clog2(dmem_depth)-1:0]    dm_idx;

	// --------------------
	// EX/MEM register
	// --------------------

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			xm_valid <= 1'b0;
		end else begin
			xm_valid <= xr.valid;
		end
	end

	always_ff @(posedge clk) begin
		xm_wb_data    <= xr.wb_data;
		xm_dst        <= xr.dst;
		xm_reg_write  <= xr.reg_write;
		xm_mem_read   <= xr.mem_read;
		xm_mem_write  <= xr.mem_write;
		xm_mem_addr   <= xr.mem_addr;
		xm_store_data <= xr.store_data;
		xm_halt       <= xr.halt;
	end

	// Loads have no data yet here, the stall covers them
	assign mem_fwd_en   = xm_valid && xm_reg_write && !xm_mem_read;
	assign mem_fwd_reg  = xm_dst;
	assign mem_fwd_data = xm_wb_data;

	// --------------------
	// Data memory and MEM/WB
	// --------------------

	assign dm_idx = xm_mem_addr[$clog2(dmem_depth):1];

	// Stores from behind a HLT are dropped
	always_ff @(posedge clk) begin
		if (xm_valid && xm_mem_write && !halted) begin
			dmem[dm_idx] <= xm_store_data;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			mw_valid <= 1'b0;
		end else begin
			mw_valid <= xm_valid;
		end
	end

	// Synchronous read lands straight in MEM/WB
	always_ff @(posedge clk) begin
		mw_reg_write <= xm_reg_write;
		mw_dst       <= xm_dst;
		mw_data      <= xm_mem_read ? dmem[dm_idx] : xm_wb_data;
	end

	// Set as the HLT enters MEM/WB, sticky until reset
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			halted <= 1'b0;
		end else if (xm_valid && xm_halt) begin
			halted <= 1'b1;
		end
	end

	assign wb_en   = mw_valid && mw_reg_write && !halted;
	assign wb_reg  = mw_dst;
	assign wb_data = mw_data;

	a_halt_final: assert property (@(posedge clk) disable iff (!rst_n)
		halted |=> halted && !wb_en);

endmodule

/* hw/cpu.sv */
module cpu (
	input  logic                           clk,
	input  logic                           rst_n,
	output logic                           hlt,
	output logic [cpu_pkg::word_w-1:0]     pc_out,
	output logic                           wb_en,
	output logic [cpu_pkg::reg_addr_w-1:0] wb_reg,
	output logic [cpu_pkg::word_w-1:0]     wb_data
);
	import cpu_pkg::*;

	// Fetch to decode
	logic [word_w-1:0]     if_pc_plus2;
	logic [word_w-1:0]     if_instr;
	logic                  if_valid;

	// Hazard and redirect
	logic                  stall;
	logic                  branch_taken;
	logic [word_w-1:0]     branch_target;
	logic                  ex_mem_read;
	logic [reg_addr_w-1:0] ex_dst;

	// Mem-stage forward
	logic                  mem_fwd_en;
	logic [reg_addr_w-1:0] mem_fwd_reg;
	logic [word_w-1:0]     mem_fwd_data;

	dx_bus dx ();
	xr_bus xr ();

	fetch_unit u_fetch (
		.clk(clk),
		.rst_n(rst_n),
		.stall(stall),
		.halted(hlt),
		.branch_taken(branch_taken),
		.branch_target(branch_target),
		.pc(pc_out),
		.pc_plus2(if_pc_plus2),
		.instr(if_instr),
		.valid(if_valid)
	);

	decode_stage u_decode (
		.clk(clk),
		.rst_n(rst_n),
		.pc_plus2(if_pc_plus2),
		.instr(if_instr),
		.valid(if_valid),
		.branch_taken(branch_taken),
		.wb_en(wb_en),
		.wb_reg(wb_reg),
		.wb_data(wb_data),
		.ex_mem_read(ex_mem_read),
		.ex_dst(ex_dst),
		.stall(stall),
		.dx(dx.source)
	);

	execute_stage u_execute (
		.clk(clk),
		.rst_n(rst_n),
		.stall(stall),
		.dx(dx.sink),
		.mem_fwd_en(mem_fwd_en),
		.mem_fwd_reg(mem_fwd_reg),
		.mem_fwd_data(mem_fwd_data),
		.wb_en(wb_en),
		.wb_reg(wb_reg),
		.wb_data(wb_data),
		.branch_taken(branch_taken),
		.branch_target(branch_target),
		.ex_mem_read(ex_mem_read),
		.ex_dst(ex_dst),
		.xr(xr.source)
	);

	result_stage u_result (
		.clk(clk),
		.rst_n(rst_n),
		.xr(xr.sink),
		.mem_fwd_en(mem_fwd_en),
		.mem_fwd_reg(mem_fwd_reg),
		.mem_fwd_data(mem_fwd_data),
		.wb_en(wb_en),
		.wb_reg(wb_reg),
		.wb_data(wb_data),
		.halted(hlt)
	);

endmodule

/* tb/cpu_tb.sv */
module cpu_tb;
	import cpu_pkg::*;

	// Model runs are bounded so a looping program cannot hang time 0
	localparam int max_steps = 256;

	logic                  clk;
	logic                  rst_n;
	logic                  hlt;
	logic [word_w-1:0]     pc_out;
	logic                  wb_en;
	logic [reg_addr_w-1:0] wb_reg;
	logic [word_w-1:0]     wb_data;

	// Reference model state
	logic [word_w-1:0]     prog_m [imem_depth];
	logic [word_w-1:0]     regs_m [16];
	logic [word_w-1:0]     dmem_m [dmem_depth];

	// Expected register writes in program order
	logic [reg_addr_w-1:0] exp_reg [max_steps];
	logic [word_w-1:0]     exp_val [max_steps];
	logic [8:0]            exp_count;
	int                    model_steps;
	bit                    model_ready = 1'b0;

	// Observed write-back progress
	logic [8:0]            wr_count;
	logic [7:0]            wr_idx;
	int                    cyc = 0;

	cpu DUT (
		.clk(clk),
		.rst_n(rst_n),
		.hlt(hlt),
		.pc_out(pc_out),
		.wb_en(wb_en),
		.wb_reg(wb_reg),
		.wb_data(wb_data)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	task automatic fail_run(input string msg);
		$display("%s", msg);
		$display("=== FAIL ===");
		$fatal(1, "simulation stopped");
	endtask

	// Condition codes against the current flags
	function automatic logic cond_met(input logic [2:0] c, input flags_t f);
		case (cond_e'(c))
			NE:      return !f.z;
			EQ:      return f.z;
			GT:      return !f.z && !f.n;
			LT:      return f.n;
			GE:      return f.z || !f.n;
			LE:      return f.z || f.n;
			OV:      return f.v;
			default: return 1'b1;
		endcase
	endfunction

	// --------------------
	// ISA reference model
	// --------------------

	// One instruction at a time, no pipeline
	task automatic run_model();
		logic [word_w-1:0] pc;
		logic [word_w-1:0] w;
		logic [word_w-1:0] a;
		logic [word_w-1:0] b;
		logic [word_w-1:0] res;
		logic [word_w-1:0] addr;
		logic [3:0]        sh;
		opcode_e           op;
		flags_t            f;
		logic              wr;
		logic              done;
		// Words past the program read as HLT
		for (int i = 0; i < imem_depth; i++) begin
			prog_m[i] = 16'hF000;
		end
		for (int i = 0; i < dmem_depth; i++) begin
			dmem_m[i] = '0;
		end
		for (int i = 0; i < 16; i++) begin
			regs_m[i] = '0;
		end
		$readmemh("prog.hex", prog_m);
		pc          = '0;
		f           = '0;
		done        = 1'b0;
		exp_count   = '0;
		model_steps = 0;
		while (!done && model_steps < max_steps) begin
			w  = prog_m[pc[8:1]];
			op = opcode_e'(w[15:12]);
			sh = w[3:0];
			a  = regs_m[w[7:4]];
			b  = regs_m[w[3:0]];
			// Aligned rs plus imm4 words
			addr = {a[word_w-1:1], 1'b0} + {{11{w[3]}}, w[3:0], 1'b0};
			res  = '0;
			wr   = 1'b1;
			model_steps++;
			pc = pc + 16'd2;
			case (op)
				ADD: begin
					res = a + b;
					f.v = (a[15] == b[15]) && (res[15] != a[15]);
					f.n = res[15];
				end
				SUB: begin
					res = a - b;
					f.v = (a[15] != b[15]) && (res[15] != a[15]);
					f.n = res[15];
				end
				XOR: res = a ^ b;
				AND: res = a & b;
				SLL: res = a << sh;
				SRA: res = $signed(a) >>> sh;
				ROR: res = (a >> sh) | (a << (5'd16 - {1'b0, sh}));
				LW:  res = dmem_m[addr[8:1]];
				SW: begin
					dmem_m[addr[8:1]] = regs_m[w[11:8]];
					wr = 1'b0;
				end
				// Byte merges keep the other half of rd
				LHB: res = {w[7:0], regs_m[w[11:8]][7:0]};
				LLB: res = {regs_m[w[11:8]][15:8], w[7:0]};
				B: begin
					if (cond_met(w[11:9], f)) begin
						pc = pc + {{6{w[8]}}, w[8:0], 1'b0};
					end
					wr = 1'b0;
				end
				BR: begin
					if (cond_met(w[11:9], f)) begin
						pc = a;
					end
					wr = 1'b0;
				end
				PCS: res = pc;
				HLT: begin
					done = 1'b1;
					wr   = 1'b0;
				end
				default: wr = 1'b0;
			endcase
			// Zero flag from every ALU op
			if (op inside {ADD, SUB, XOR, AND, SLL, SRA, ROR}) begin
				f.z = (res == '0);
			end
			if (wr) begin
				regs_m[w[11:8]]         = res;
				exp_reg[exp_count[7:0]] = w[11:8];
				exp_val[exp_count[7:0]] = res;
				exp_count               = exp_count + 9'd1;
			end
		end
		if (!done) begin
			fail_run("The reference model ran out of steps without reaching a HLT");
		end
	endtask

	// --------------------
	// Checks
	// --------------------

	always @(posedge clk) begin
		cyc <= cyc + 1;
	end

	always @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_count <= '0;
		end else if (wb_en) begin
			wr_count <= wr_count + 9'd1;
		end
	end

	assign wr_idx = wr_count[7:0];

	// First edge skipped, reset not yet applied
	a_reset_quiet: assert property (@(posedge clk)
		(!rst_n && cyc != 0) |-> (!hlt && !wb_en && pc_out == '0))
		else fail_run($sformatf("Error at time %0t: hlt, wb_en or pc_out not zero in reset",
			$time));

	// Wrong-path writes would shift the order
	a_write_extra: assert property (@(posedge clk) disable iff (!rst_n)
		wb_en |-> wr_count < exp_count)
		else fail_run($sformatf("Error at time %0t: write to r%0d beyond the %0d expected",
			$time, $sampled(wb_reg), exp_count));

	a_write_match: assert property (@(posedge clk) disable iff (!rst_n)
		(wb_en && wr_count < exp_count) |->
			(wb_reg == exp_reg[wr_idx] && wb_data == exp_val[wr_idx]))
		else fail_run($sformatf("Error at time %0t: write %0d is r%0d = %h, expected r%0d = %h",
			$time, $sampled(wr_idx), $sampled(wb_reg), $sampled(wb_data),
			exp_reg[$sampled(wr_idx)], exp_val[$sampled(wr_idx)]));

	a_halt_count: assert property (@(posedge clk) disable iff (!rst_n)
		$rose(hlt) |-> wr_count == exp_count)
		else fail_run($sformatf("Error at time %0t: hlt rose after %0d writes, expected %0d",
			$time, $sampled(wr_count), exp_count));

	a_halt_quiet: assert property (@(posedge clk) disable iff (!rst_n)
		hlt |-> !wb_en)
		else fail_run($sformatf("Error at time %0t: register write after halt", $time));

	a_halt_pc: assert property (@(posedge clk) disable iff (!rst_n)
		hlt |=> $stable(pc_out))
		else fail_run($sformatf("Error at time %0t: pc_out moved after halt", $time));

	// --------------------
	// Run control
	// --------------------

	initial begin
		rst_n = 1'b0;
		run_model();
		model_ready = 1'b1;
		repeat (8) @(negedge clk);
		rst_n = 1'b1;
		while (hlt !== 1'b1) begin
			@(negedge clk);
		end
		// A few halted cycles for the hold checks
		repeat (6) @(negedge clk);
		if (wr_count == exp_count) begin
			$display("=== PASS ===");
			$finish;
		end else begin
			fail_run($sformatf("Error at time %0t: %0d writes seen, expected %0d",
				$time, wr_count, exp_count));
		end
	end

	// Generous bound, five cycles per model step
	initial begin
		wait (model_ready);
		repeat (model_steps * 5 + 20) @(posedge clk);
		fail_run("Timeout: the CPU did not halt within the expected number of cycles");
	end

endmodule

/* prog.hex */
// One 16-bit instruction per line, word 0 first
// Fields: opcode[15:12], then rd rs rt/imm4, rd imm8, or cond[11:9] imm9
E100 // PCS r1, first known value
1011 // SUB r0 = r1 - r1
0200 // ADD r2 = 0
B234 // LLB r2
A212 // LHB r2
0300 // ADD r3 = 0
B3CD // LLB r3
A3AB // LHB r3
0423 // ADD r4 = r2 + r3
1542 // SUB r5, dependent on r4
2654 // XOR r6, both forward paths
3765 // AND r7
4873 // SLL r8 by 3
5934 // SRA r9 by 4
6A94 // ROR r10 by 4
9412 // SW r4 at r1 + 2 words
9A10 // SW r10 at r1
8B12 // LW r11
0CB2 // ADD r12, load-use on r11
8D10 // LW r13
1E2D // SUB r14, load-use on r13
C202 // B EQ, not taken
C401 // B GT, taken
0F22 // wrong path
0F34 // ADD r15, signed overflow
CC01 // B OV, taken
2222 // wrong path
C605 // B LT, not taken
1000 // SUB r0, sets zero
C005 // B NE, not taken
CA01 // B LE, taken
0111 // wrong path
E500 // PCS r5
1666 // SUB r6 = 0
B64A // LLB r6, BR target
DE60 // BR always via r6
0777 // wrong path
0956 // ADD r9, BR target lands here
9904 // SW r9
8A04 // LW r10
F000 // HLT

/* all.f */
hw/cpu_pkg.sv
hw/cpu_bus.sv
hw/fetch_unit.sv
hw/decode_stage.sv
hw/execute_stage.sv
hw/result_stage.sv
hw/cpu.sv
tb/cpu_tb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --assert -f all.f --top-module cpu_tb -o cpu_sim
./obj_dir/cpu_sim
